// File: hw/issue_pkg.sv
package issue_pkg;

    // core geometry
    localparam int NUM_THREADS = 4;
    localparam int NUM_WARPS   = 4;
    localparam int NT_BITS     = $clog2(NUM_THREADS);
    localparam int NW_BITS     = $clog2(NUM_WARPS);

    // instruction field widths
    localparam int NR_BITS       = 5;
    localparam int CSR_ADDR_BITS = 12;
    localparam int NRI_BITS      = 5;
    localparam int OP_BITS       = 4;
    localparam int MOD_BITS      = 3;

    // execution unit selector
    typedef enum logic [2:0] {
        EX_NOP = 3'd0,
        EX_ALU = 3'd1,
        EX_LSU = 3'd2,
        EX_CSR = 3'd3,
        EX_GPU = 3'd4
    } ex_type_e;

    typedef logic [NUM_THREADS-1:0][31:0] thread_words_t;

    typedef struct packed {
        logic [NW_BITS-1:0]     wid;
        logic [NUM_THREADS-1:0] tmask;
        logic [31:0]            pc;
        ex_type_e               ex_type;
        logic [OP_BITS-1:0]     op_type;
        logic [MOD_BITS-1:0]    op_mod;
        logic [31:0]            imm;
        logic                   use_pc;
        logic                   use_imm;
        logic [NR_BITS-1:0]     rd;
        logic                   wb;
    } issue_req_t;

    typedef struct packed {
        thread_words_t rs1_data;
        thread_words_t rs2_data;
    } gpr_rsp_t;

    typedef struct packed {
        issue_req_t req;
        gpr_rsp_t   gpr;
    } issue_word_t;

    typedef struct packed {
        logic [NW_BITS-1:0]     wid;
        logic [NUM_THREADS-1:0] tmask;
        logic [31:0]            pc;
        logic [31:0]            next_pc;
        logic [OP_BITS-1:0]     op_type;
        logic [MOD_BITS-1:0]    op_mod;
        logic [31:0]            imm;
        logic                   use_pc;
        logic                   use_imm;
        logic [NR_BITS-1:0]     rd;
        logic                   wb;
        logic [NT_BITS-1:0]     tid;
        thread_words_t          rs1_data;
        thread_words_t          rs2_data;
    } alu_req_t;

    typedef struct packed {
        logic [NW_BITS-1:0]     wid;
        logic [NUM_THREADS-1:0] tmask;
        logic [31:0]            pc;
        logic [OP_BITS-1:0]     op_type;
        logic                   is_fence;
        logic [31:0]            offset;
        logic [NR_BITS-1:0]     rd;
        logic                   wb;
        thread_words_t          base_addr;
        thread_words_t          store_data;
        logic                   is_prefetch;
    } lsu_req_t;

    typedef struct packed {
        logic [NW_BITS-1:0]       wid;
        logic [NUM_THREADS-1:0]   tmask;
        logic [31:0]              pc;
        logic [OP_BITS-1:0]       op_type;
        logic [CSR_ADDR_BITS-1:0] addr;
        logic [NR_BITS-1:0]       rd;
        logic                     wb;
        logic                     use_imm;
        logic [NRI_BITS-1:0]      csr_imm;
        logic [31:0]              rs1_data;
    } csr_req_t;

    typedef struct packed {
        logic [NW_BITS-1:0]     wid;
        logic [NUM_THREADS-1:0] tmask;
        logic [31:0]            pc;
        logic [31:0]            next_pc;
        logic [OP_BITS-1:0]     op_type;
        logic [MOD_BITS-1:0]    op_mod;
        logic [NR_BITS-1:0]     rd;
        logic                   wb;
        logic [NT_BITS-1:0]     tid;
        thread_words_t          rs1_data;
        thread_words_t          rs2_data;
    } gpu_req_t;

endpackage

// File: hw/tid_select.sv
`timescale 1ns/1ps

module tid_select (
    input  logic [issue_pkg::NUM_THREADS-1:0] tmask,
    output logic [issue_pkg::NT_BITS-1:0]     tid
);

    // scan from the top so the lowest set bit wins
    always_comb begin
        tid = '0;
        for (int i = issue_pkg::NUM_THREADS - 1; i >= 0; i--) begin
            if (tmask[i]) begin
                tid = i[issue_pkg::NT_BITS-1:0];
            end
        end
    end

endmodule

// File: hw/skid_buffer.sv
`timescale 1ns/1ps

module skid_buffer #(
    parameter int DATA_W  = 32,
    parameter bit OUT_REG = 1'b1
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              valid_in,
    output logic              ready_in,
    input  logic [DATA_W-1:0] data_in,
    output logic              valid_out,
    input  logic              ready_out,
    output logic [DATA_W-1:0] data_out
);
    logic              skid_valid;
    logic [DATA_W-1:0] skid_data;

    // producer only sees back-pressure once the skid entry holds an item
    assign ready_in = !skid_valid;

    if (OUT_REG) begin : g_out_reg
        logic              main_valid;
        logic [DATA_W-1:0] main_data;
        logic              main_load;

        // main entry empty or drained this cycle
        assign main_load = ready_out || !main_valid;

        always_ff @(posedge clk) begin
            if (reset) begin
                main_valid <= 1'b0;
                skid_valid <= 1'b0;
            end else if (main_load) begin
                main_valid <= skid_valid || valid_in;
                skid_valid <= 1'b0;
            end else if (valid_in && ready_in) begin
                skid_valid <= 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (main_load) begin
                main_data <= skid_valid ? skid_data : data_in;
            end
            if (!main_load && valid_in && ready_in) begin
                skid_data <= data_in;
            end
        end

        assign valid_out = main_valid;
        assign data_out  = main_data;
    end else begin : g_out_comb
        always_ff @(posedge clk) begin
            if (reset) begin
                skid_valid <= 1'b0;
            end else if (ready_out) begin
                skid_valid <= 1'b0;
            end else if (valid_in && ready_in) begin
                skid_valid <= 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (valid_in && ready_in && !ready_out) begin
                skid_data <= data_in;
            end
        end

        // pass straight through while nothing is parked
        assign valid_out = skid_valid || valid_in;
        assign data_out  = skid_valid ? skid_data : data_in;
    end

endmodule

// File: hw/issue_slot.sv
`timescale 1ns/1ps

module issue_slot (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   in_valid,
    output logic                   in_ready,
    input  issue_pkg::issue_req_t  in_req,
    input  issue_pkg::gpr_rsp_t    in_gpr,

    output logic                   slot_valid,
    input  logic                   slot_ready,
    output issue_pkg::issue_word_t slot_word
);
    logic                   valid_r;
    issue_pkg::issue_word_t word_r;
    logic                   load;

    // slot can take a new word when empty or being emptied
    assign in_ready = !valid_r || slot_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= 1'b0;
        end else if (in_ready) begin
            valid_r <= in_valid;
        end
    end

    // instruction and operands travel together from here on
    always_ff @(posedge clk) begin
        if (load) begin
            word_r.req <= in_req;
            word_r.gpr <= in_gpr;
        end
    end

    assign slot_valid = valid_r;
    assign slot_word  = word_r;

endmodule

// File: hw/instr_demux.sv
`timescale 1ns/1ps

module instr_demux #(
    parameter bit OUT_REG = 1'b1
) (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   slot_valid,
    output logic                   slot_ready,
    input  issue_pkg::issue_word_t slot_word,

    output logic                   alu_valid,
    input  logic                   alu_ready,
    output issue_pkg::alu_req_t    alu_req,

    output logic                   lsu_valid,
    input  logic                   lsu_ready,
    output issue_pkg::lsu_req_t    lsu_req,

    output logic                   csr_valid,
    input  logic                   csr_ready,
    output issue_pkg::csr_req_t    csr_req,

    output logic                   gpu_valid,
    input  logic                   gpu_ready,
    output issue_pkg::gpu_req_t    gpu_req
);
    issue_pkg::issue_req_t        req;
    issue_pkg::gpr_rsp_t          gpr;
    logic [issue_pkg::NT_BITS-1:0] tid;
    logic [31:0]                  next_pc;

    logic alu_push, lsu_push, csr_push, gpu_push;
    logic alu_free, lsu_free, csr_free, gpu_free;

    issue_pkg::alu_req_t alu_in;
    issue_pkg::lsu_req_t lsu_in;
    issue_pkg::csr_req_t csr_in;
    issue_pkg::gpu_req_t gpu_in;

    assign req     = slot_word.req;
    assign gpr     = slot_word.gpr;
    assign next_pc = req.pc + 32'd4;

    tid_select tid_select_inst (
        .tmask (req.tmask),
        .tid   (tid)
    );

    assign alu_push = slot_valid && (req.ex_type == issue_pkg::EX_ALU);
    assign lsu_push = slot_valid && (req.ex_type == issue_pkg::EX_LSU);
    assign csr_push = slot_valid && (req.ex_type == issue_pkg::EX_CSR);
    assign gpu_push = slot_valid && (req.ex_type == issue_pkg::EX_GPU);

    always_comb begin
        alu_in = '{wid: req.wid, tmask: req.tmask, pc: req.pc, next_pc: next_pc,
                   op_type: req.op_type, op_mod: req.op_mod, imm: req.imm,
                   use_pc: req.use_pc, use_imm: req.use_imm, rd: req.rd, wb: req.wb,
                   tid: tid, rs1_data: gpr.rs1_data, rs2_data: gpr.rs2_data};

        // op_mod carries the memory flags
        lsu_in = '{wid: req.wid, tmask: req.tmask, pc: req.pc, op_type: req.op_type,
                   is_fence: req.op_mod[0], offset: req.imm, rd: req.rd, wb: req.wb,
                   base_addr: gpr.rs1_data, store_data: gpr.rs2_data,
                   is_prefetch: req.op_mod[1]};

        // imm packs csr address below the csr immediate
        csr_in = '{wid: req.wid, tmask: req.tmask, pc: req.pc, op_type: req.op_type,
                   addr: req.imm[issue_pkg::CSR_ADDR_BITS-1:0], rd: req.rd, wb: req.wb,
                   use_imm: req.use_imm,
                   csr_imm: req.imm[issue_pkg::CSR_ADDR_BITS +: issue_pkg::NRI_BITS],
                   rs1_data: gpr.rs1_data[tid]};

        gpu_in = '{wid: req.wid, tmask: req.tmask, pc: req.pc, next_pc: next_pc,
                   op_type: req.op_type, op_mod: req.op_mod, rd: req.rd, wb: req.wb,
                   tid: tid, rs1_data: gpr.rs1_data, rs2_data: gpr.rs2_data};
    end

    skid_buffer #(
        .DATA_W  ($bits(issue_pkg::alu_req_t)),
        .OUT_REG (OUT_REG)
    ) alu_buffer (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (alu_push),
        .ready_in  (alu_free),
        .data_in   (alu_in),
        .valid_out (alu_valid),
        .ready_out (alu_ready),
        .data_out  (alu_req)
    );

    skid_buffer #(
        .DATA_W  ($bits(issue_pkg::lsu_req_t)),
        .OUT_REG (OUT_REG)
    ) lsu_buffer (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (lsu_push),
        .ready_in  (lsu_free),
        .data_in   (lsu_in),
        .valid_out (lsu_valid),
        .ready_out (lsu_ready),
        .data_out  (lsu_req)
    );

    skid_buffer #(
        .DATA_W  ($bits(issue_pkg::csr_req_t)),
        .OUT_REG (OUT_REG)
    ) csr_buffer (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (csr_push),
        .ready_in  (csr_free),
        .data_in   (csr_in),
        .valid_out (csr_valid),
        .ready_out (csr_ready),
        .data_out  (csr_req)
    );

    skid_buffer #(
        .DATA_W  ($bits(issue_pkg::gpu_req_t)),
        .OUT_REG (OUT_REG)
    ) gpu_buffer (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (gpu_push),
        .ready_in  (gpu_free),
        .data_in   (gpu_in),
        .valid_out (gpu_valid),
        .ready_out (gpu_ready),
        .data_out  (gpu_req)
    );

    // head of line waits on its own unit only
    always_comb begin
        case (req.ex_type)
            issue_pkg::EX_ALU: slot_ready = alu_free;
            issue_pkg::EX_LSU: slot_ready = lsu_free;
            issue_pkg::EX_CSR: slot_ready = csr_free;
            issue_pkg::EX_GPU: slot_ready = gpu_free;
            // nops and unknown types are simply dropped
            default:           slot_ready = 1'b1;
        endcase
    end

endmodule

// File: hw/issue_top.sv
`timescale 1ns/1ps

module issue_top #(
    parameter bit OUT_REG = 1'b1
) (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  in_valid,
    output logic                  in_ready,
    input  issue_pkg::issue_req_t in_req,
    input  issue_pkg::gpr_rsp_t   in_gpr,

    output logic                  alu_valid,
    input  logic                  alu_ready,
    output issue_pkg::alu_req_t   alu_req,

    output logic                  lsu_valid,
    input  logic                  lsu_ready,
    output issue_pkg::lsu_req_t   lsu_req,

    output logic                  csr_valid,
    input  logic                  csr_ready,
    output issue_pkg::csr_req_t   csr_req,

    output logic                  gpu_valid,
    input  logic                  gpu_ready,
    output issue_pkg::gpu_req_t   gpu_req
);
    logic                   slot_valid;
    logic                   slot_ready;
    issue_pkg::issue_word_t slot_word;

    issue_slot issue_slot_inst (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_req     (in_req),
        .in_gpr     (in_gpr),
        .slot_valid (slot_valid),
        .slot_ready (slot_ready),
        .slot_word  (slot_word)
    );

    instr_demux #(
        .OUT_REG (OUT_REG)
    ) instr_demux_inst (
        .clk        (clk),
        .reset      (reset),
        .slot_valid (slot_valid),
        .slot_ready (slot_ready),
        .slot_word  (slot_word),
        .alu_valid  (alu_valid),
        .alu_ready  (alu_ready),
        .alu_req    (alu_req),
        .lsu_valid  (lsu_valid),
        .lsu_ready  (lsu_ready),
        .lsu_req    (lsu_req),
        .csr_valid  (csr_valid),
        .csr_ready  (csr_ready),
        .csr_req    (csr_req),
        .gpu_valid  (gpu_valid),
        .gpu_ready  (gpu_ready),
        .gpu_req    (gpu_req)
    );

endmodule

// File: tests/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset spans two rising edges and drops on a falling one
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: tests/tb_issue_top.sv
`timescale 1ns/1ps

module tb_issue_top;

    localparam int LSU_N = 8;
    localparam int CSR_N = 12;
    localparam int MIX_N = 30;
    localparam int BP_N  = 16;
    localparam int TP_N  = 200;
    localparam int NUM_INSTR = 1 + LSU_N + CSR_N + MIX_N + BP_N + TP_N;
    localparam int WATCHDOG_CYCLES = 20 * NUM_INSTR + 200;

    logic clk;
    logic reset;
    logic in_valid;
    logic in_ready;
    issue_pkg::issue_req_t in_req;
    issue_pkg::gpr_rsp_t   in_gpr;
    logic alu_valid, alu_ready, lsu_valid, lsu_ready;
    logic csr_valid, csr_ready, gpu_valid, gpu_ready;
    issue_pkg::alu_req_t alu_req, alu_exp;
    issue_pkg::lsu_req_t lsu_req, lsu_exp;
    issue_pkg::csr_req_t csr_req, csr_exp;
    issue_pkg::gpu_req_t gpu_req, gpu_exp;

    issue_pkg::alu_req_t alu_q[$];
    issue_pkg::lsu_req_t lsu_q[$];
    issue_pkg::csr_req_t csr_q[$];
    issue_pkg::gpu_req_t gpu_q[$];

    integer seed = 32'hfceb_85a6;
    int errors = 0;
    int cycle = 0;
    int accept_cycle;
    int alu_last;

    tb_clk_gen tb_clk_gen_inst (.clk(clk), .reset(reset));

    issue_top #(.OUT_REG(1'b1)) issue_top_inst (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_ready(in_ready), .in_req(in_req), .in_gpr(in_gpr),
        .alu_valid(alu_valid), .alu_ready(alu_ready), .alu_req(alu_req),
        .lsu_valid(lsu_valid), .lsu_ready(lsu_ready), .lsu_req(lsu_req),
        .csr_valid(csr_valid), .csr_ready(csr_ready), .csr_req(csr_req),
        .gpu_valid(gpu_valid), .gpu_ready(gpu_ready), .gpu_req(gpu_req)
    );

    always @(posedge clk) cycle <= cycle + 1;

    task automatic check(input string name, input logic [511:0] exp, input logic [511:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s expected %0h got %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic note_failure(input string what);
        $display("%s", what);
        errors++;
    endtask

    function automatic logic [issue_pkg::NT_BITS-1:0] lowest_active(input logic [3:0] tmask);
        logic found;
        found = 1'b0;
        lowest_active = '0;
        for (int i = 0; i < issue_pkg::NUM_THREADS; i++) begin
            if (tmask[i] && !found) begin
                lowest_active = i;
                found = 1'b1;
            end
        end
    endfunction

    function automatic issue_pkg::issue_req_t rand_req(input logic [2:0] ex);
        issue_pkg::issue_req_t r;
        logic [95:0] bits;
        bits = {$random(seed), $random(seed), $random(seed)};
        r = bits[$bits(issue_pkg::issue_req_t)-1:0];
        r.ex_type = issue_pkg::ex_type_e'(ex);
        return r;
    endfunction

    function automatic issue_pkg::gpr_rsp_t rand_gpr();
        issue_pkg::gpr_rsp_t g;
        for (int i = 0; i < 2 * issue_pkg::NUM_THREADS; i++) begin
            g[i*32 +: 32] = $random(seed);
        end
        return g;
    endfunction

    task automatic expect_outputs(input issue_pkg::issue_req_t r, input issue_pkg::gpr_rsp_t g);
        logic [issue_pkg::NT_BITS-1:0] t;
        t = lowest_active(r.tmask);
        case (r.ex_type)
            issue_pkg::EX_ALU: alu_q.push_back('{wid: r.wid, tmask: r.tmask, pc: r.pc,
                next_pc: r.pc + 32'd4, op_type: r.op_type, op_mod: r.op_mod, imm: r.imm,
                use_pc: r.use_pc, use_imm: r.use_imm, rd: r.rd, wb: r.wb, tid: t,
                rs1_data: g.rs1_data, rs2_data: g.rs2_data});
            issue_pkg::EX_LSU: lsu_q.push_back('{wid: r.wid, tmask: r.tmask, pc: r.pc,
                op_type: r.op_type, is_fence: r.op_mod[0], offset: r.imm, rd: r.rd, wb: r.wb,
                base_addr: g.rs1_data, store_data: g.rs2_data, is_prefetch: r.op_mod[1]});
            issue_pkg::EX_CSR: csr_q.push_back('{wid: r.wid, tmask: r.tmask, pc: r.pc,
                op_type: r.op_type, addr: r.imm[11:0], rd: r.rd, wb: r.wb,
                use_imm: r.use_imm, csr_imm: r.imm[16:12], rs1_data: g.rs1_data[t]});
            issue_pkg::EX_GPU: gpu_q.push_back('{wid: r.wid, tmask: r.tmask, pc: r.pc,
                next_pc: r.pc + 32'd4, op_type: r.op_type, op_mod: r.op_mod, rd: r.rd,
                wb: r.wb, tid: t, rs1_data: g.rs1_data, rs2_data: g.rs2_data});
            // nop and undefined types expect nothing
            default: ;
        endcase
    endtask

    // holds valid and data until the slot takes them
    task automatic send(input issue_pkg::issue_req_t r, input issue_pkg::gpr_rsp_t g);
        @(negedge clk);
        in_valid = 1'b1;
        in_req   = r;
        in_gpr   = g;
        @(posedge clk);
        while (!in_ready) @(posedge clk);
        accept_cycle = cycle;
        expect_outputs(r, g);
    endtask

    task automatic drain();
        int i;
        @(negedge clk);
        in_valid = 1'b0;
        for (i = 0; i < 100; i++) begin
            if (alu_q.size() + lsu_q.size() + csr_q.size() + gpu_q.size() == 0) break;
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    always @(posedge clk) begin
        if (!reset && alu_valid && alu_ready) begin
            alu_last = cycle;
            if (alu_q.size() == 0) begin
                note_failure("ALU output appeared with no matching input");
            end else begin
                alu_exp = alu_q.pop_front();
                check("alu_req.next_pc", alu_exp.next_pc, alu_req.next_pc);
                check("alu_req.tid", alu_exp.tid, alu_req.tid);
                check("alu_req", alu_exp, alu_req);
            end
        end
    end

    always @(posedge clk) begin
        if (!reset && lsu_valid && lsu_ready) begin
            if (lsu_q.size() == 0) begin
                note_failure("LSU output appeared with no matching input");
            end else begin
                lsu_exp = lsu_q.pop_front();
                check("lsu_req.is_fence", lsu_exp.is_fence, lsu_req.is_fence);
                check("lsu_req.is_prefetch", lsu_exp.is_prefetch, lsu_req.is_prefetch);
                check("lsu_req", lsu_exp, lsu_req);
            end
        end
    end

    always @(posedge clk) begin
        if (!reset && csr_valid && csr_ready) begin
            if (csr_q.size() == 0) begin
                note_failure("CSR output appeared with no matching input");
            end else begin
                csr_exp = csr_q.pop_front();
                check("csr_req.addr", csr_exp.addr, csr_req.addr);
                check("csr_req.csr_imm", csr_exp.csr_imm, csr_req.csr_imm);
                check("csr_req.rs1_data", csr_exp.rs1_data, csr_req.rs1_data);
                check("csr_req", csr_exp, csr_req);
            end
        end
    end

    always @(posedge clk) begin
        if (!reset && gpu_valid && gpu_ready) begin
            if (gpu_q.size() == 0) begin
                note_failure("GPU output appeared with no matching input");
            end else begin
                gpu_exp = gpu_q.pop_front();
                check("gpu_req.tid", gpu_exp.tid, gpu_req.tid);
                check("gpu_req", gpu_exp, gpu_req);
            end
        end
    end

    task automatic reset_latency_test();
        check("unit valids", 4'b0000, {alu_valid, lsu_valid, csr_valid, gpu_valid});
        check("in_ready", 1'b1, in_ready);
        send(rand_req(issue_pkg::EX_ALU), rand_gpr());
        drain();
        check("alu latency", 2, alu_last - accept_cycle);
    endtask

    task automatic lsu_field_test();
        issue_pkg::issue_req_t r;
        for (int m = 0; m < LSU_N; m++) begin
            r = rand_req(issue_pkg::EX_LSU);
            r.op_mod = m[2:0];
            send(r, rand_gpr());
        end
        drain();
    endtask

    task automatic csr_field_test();
        issue_pkg::issue_req_t r;
        for (int i = 0; i < CSR_N; i++) begin
            r = rand_req(issue_pkg::EX_CSR);
            // every fourth one has no active thread
            if (i % 4 == 0) r.tmask = '0;
            send(r, rand_gpr());
        end
        drain();
    endtask

    task automatic gpu_nop_test();
        logic [31:0] k;
        logic [2:0] ex;
        for (int i = 0; i < MIX_N; i++) begin
            k = $random(seed);
            // 0 gpu, 1 nop, 2 and 3 map to undefined codes 5 and 6
            ex = k[1] ? 3'd5 + k[0] : (k[0] ? issue_pkg::EX_NOP : issue_pkg::EX_GPU);
            send(rand_req(ex), rand_gpr());
        end
        drain();
    endtask

    task automatic backpressure_test();
        logic stalled;
        @(negedge clk);
        lsu_ready = 1'b0;
        stalled = 1'b0;
        fork
            for (int i = 0; i < BP_N; i++) begin
                send(rand_req(3'd1 + i % 4), rand_gpr());
            end
            begin
                for (int j = 0; j < 200 && !stalled; j++) begin
                    @(posedge clk);
                    stalled = !in_ready;
                end
                if (!stalled) begin
                    note_failure("in_ready never fell while the LSU was blocked");
                end else begin
                    // two in the buffer and one waiting in the slot
                    check("lsu items held at stall", 3, lsu_q.size());
                end
                repeat (10) @(posedge clk);
                @(negedge clk);
                lsu_ready = 1'b1;
            end
        join
        drain();
    endtask

    task automatic throughput_test();
        int start;
        logic [31:0] pick;
        start = 0;
        for (int i = 0; i < TP_N; i++) begin
            pick = $random(seed);
            send(rand_req(pick[2:0]), rand_gpr());
            if (i == 0) start = accept_cycle;
        end
        check("accept cycles", TP_N - 1, accept_cycle - start);
        drain();
    endtask

    initial begin
        in_valid  = 1'b0;
        in_req    = '0;
        in_gpr    = '0;
        alu_ready = 1'b1;
        lsu_ready = 1'b1;
        csr_ready = 1'b1;
        gpu_ready = 1'b1;
        wait (reset === 1'b0);
        @(negedge clk);
        reset_latency_test();
        lsu_field_test();
        csr_field_test();
        gpu_nop_test();
        backpressure_test();
        throughput_test();
        if (alu_q.size() != 0) note_failure("missing outputs on the ALU unit");
        if (lsu_q.size() != 0) note_failure("missing outputs on the LSU unit");
        if (csr_q.size() != 0) note_failure("missing outputs on the CSR unit");
        if (gpu_q.size() != 0) note_failure("missing outputs on the GPU unit");
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: sources.f
hw/issue_pkg.sv
hw/tid_select.sv
hw/skid_buffer.sv
hw/issue_slot.sv
hw/instr_demux.sv
hw/issue_top.sv
tests/tb_clk_gen.sv
tests/tb_issue_top.sv

// File: Bender.yml
package:
  name: issue_slice

sources:
  - files:
      - hw/issue_pkg.sv
      - hw/tid_select.sv
      - hw/skid_buffer.sv
      - hw/issue_slot.sv
      - hw/instr_demux.sv
      - hw/issue_top.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_issue_top.sv
